// ==== list.f ====
+incdir+tests
logic/isa_pkg.sv
logic/commit_pkg.sv
logic/load_format.sv
logic/late_alu.sv
logic/load_merge.sv
logic/commit_stage.sv
logic/commit_regfile.sv
logic/commit_top.sv
tests/commit_tb.sv

// ==== logic/commit_pkg.sv ====
`default_nettype none

package commit_pkg;

    import isa_pkg::*;

    // fixed general exception vector
    localparam word_t exc_entry = 32'hbfc0_0380;

    typedef struct packed {
        logic  taken;
        word_t destpc;
    } pred_t;

    // one slot as it leaves execute
    typedef struct packed {
        instr_t     instr;
        word_t      pcplus4;
        creg_addr_t srcreg_a;
        creg_addr_t srcreg_b;
        // execute-time source a, JR target
        word_t      srca;
        word_t      result;
        creg_addr_t destreg;
        word_t      hiresult;
        word_t      loresult;
        logic       taken;
        pred_t      pred;
        logic       valid;
        logic       ready;
    } exec_data_t;

    typedef struct packed {
        logic  valid;
        word_t target;
    } redirect_t;

    // index 1 is the older slot
    typedef struct packed {
        creg_addr_t [1:0] destreg;
        word_t [1:0]      result;
        logic [1:0]       wen;
        logic [1:0]       ready;
        logic [1:0]       hiwrite;
        logic [1:0]       lowrite;
        word_t [1:0]      hidata;
        word_t [1:0]      lodata;
    } bypass_upd_t;

    typedef struct packed {
        logic  wen;
        word_t pc;
        logic  taken;
        word_t target;
    } bpb_update_t;

    typedef struct packed {
        word_t      rd;
        word_t      addr;
        logic [1:0] size;
    } mem_resp_t;

endpackage

`default_nettype wire

// ==== logic/commit_regfile.sv ====
`timescale 1ns/1ns
`default_nettype none

module commit_regfile (
    input  wire                               clk,
    input  wire                               rst_n,
    input  wire isa_pkg::creg_addr_t [4:0]    read_addr,
    output isa_pkg::word_t [4:0]              read_data,
    output isa_pkg::word_t [1:0]              hilo,
    input  wire                               retire,
    input  wire commit_pkg::exec_data_t [1:0] results
);

    import isa_pkg::*;

    word_t regs [0:31];
    word_t hi_q;
    word_t lo_q;

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            for (int r = 0; r < 32; r++)
            begin
                regs[r] <= '0;
            end
            hi_q <= '0;
            lo_q <= '0;
        end
        else if (retire)
        begin
            // slot 0 goes last so it wins a clash
            for (int s = 1; s >= 0; s--)
            begin
                if (results[s].valid && results[s].instr.ctl.regwrite &&
                    results[s].destreg != '0)
                begin
                    regs[results[s].destreg] <= results[s].result;
                end
                if (results[s].valid && results[s].instr.ctl.hiwrite)
                begin
                    hi_q <= results[s].hiresult;
                end
                if (results[s].valid && results[s].instr.ctl.lowrite)
                begin
                    lo_q <= results[s].loresult;
                end
            end
        end
    end

    // r0 is never written, so it reads back as zero
    always_comb
    begin
        for (int p = 0; p < 5; p++)
        begin
            read_data[p] = regs[read_addr[p]];
        end
    end

    assign hilo = {hi_q, lo_q};

endmodule

`default_nettype wire

// ==== logic/commit_stage.sv ====
`timescale 1ns/1ns
`default_nettype none

module commit_stage (
    input  wire                               clk,
    input  wire                               rst_n,
    input  wire commit_pkg::exec_data_t [1:0] bundle,
    input  wire                               exception_valid,
    input  wire isa_pkg::word_t               cp0_epc,
    input  wire                               dmem_en,
    input  wire [1:0]                         dmem_size,
    input  wire isa_pkg::word_t               dmem_addr,
    input  wire isa_pkg::word_t               dmem_rd,
    input  wire                               dmem_data_ok,
    output isa_pkg::creg_addr_t [4:0]         reg_addr,
    input  wire isa_pkg::word_t [4:0]         reg_data,
    input  wire isa_pkg::word_t [1:0]         hilo,
    output commit_pkg::exec_data_t [1:0]      results,
    output logic                              retire,
    output commit_pkg::redirect_t             redirect,
    output commit_pkg::bypass_upd_t           bypass,
    output commit_pkg::bpb_update_t           bpb_update
);

    import isa_pkg::*;
    import commit_pkg::*;

    logic        mem_in_slot1;
    decoded_op_t mem_op;
    creg_addr_t  mem_dest;
    logic        seen_q;
    word_t       data_q;
    logic        mem_done;
    mem_resp_t   resp;
    word_t       fmt_word;
    logic        jr_miss;
    logic        br_miss;
    exec_data_t  alu_out [1:0];
    exec_data_t  mem_out [1:0];

    // at most one memory slot per bundle, older one first
    assign mem_in_slot1 = bundle[1].instr.ctl.memtoreg | bundle[1].instr.ctl.memwrite;
    assign mem_op       = mem_in_slot1 ? bundle[1].instr.op : bundle[0].instr.op;
    assign mem_dest     = mem_in_slot1 ? bundle[1].destreg : bundle[0].destreg;

    // ports 0..3 feed the late ALUs, port 4 the old value for LWL/LWR
    assign reg_addr = {mem_dest, bundle[0].srcreg_b, bundle[0].srcreg_a,
                       bundle[1].srcreg_b, bundle[1].srcreg_a};

    // data_ok is a one-cycle strobe, remember it until the bundle leaves
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            seen_q <= 1'b0;
        end
        else if (retire)
        begin
            seen_q <= 1'b0;
        end
        else if (dmem_data_ok)
        begin
            seen_q <= 1'b1;
        end
    end

    always_ff @(posedge clk)
    begin
        if (dmem_data_ok)
        begin
            data_q <= dmem_rd;
        end
    end

    assign mem_done = dmem_data_ok | seen_q;
    assign retire   = ~dmem_en | mem_done;

    assign resp = '{rd: (dmem_data_ok ? dmem_rd : data_q), addr: dmem_addr, size: dmem_size};

    load_format u_load_format (
        .raw       (resp.rd),
        .addr_lo   (resp.addr[1:0]),
        .op        (mem_op),
        .old_value (reg_data[4]),
        .formatted (fmt_word)
    );

    for (genvar i = 0; i < 2; i++)
    begin : g_slot
        late_alu u_late_alu (
            .slot_in  (bundle[i]),
            .opa      (reg_data[2 - 2 * i]),
            .opb      (reg_data[3 - 2 * i]),
            .hi       (hilo[1]),
            .lo       (hilo[0]),
            .slot_out (alu_out[i])
        );

        load_merge u_load_merge (
            .slot_in   (bundle[i]),
            .resp      (resp),
            .formatted (fmt_word),
            .data_done (mem_done),
            .slot_out  (mem_out[i])
        );
    end

    always_comb
    begin
        for (int i = 0; i < 2; i++)
        begin
            if (bundle[i].instr.ctl.memtoreg | bundle[i].instr.ctl.memwrite)
            begin
                results[i] = mem_out[i];
            end
            else
            begin
                results[i] = alu_out[i];
            end
        end
    end

    // only slot 1 can hold a jump or branch, slot 0 is its delay slot
    assign jr_miss = bundle[1].instr.ctl.jr &
                     (~bundle[1].pred.taken | (bundle[1].pred.destpc != bundle[1].srca));
    assign br_miss = bundle[1].instr.ctl.branch & (bundle[1].taken != bundle[1].pred.taken);

    always_comb
    begin
        redirect = '{valid: 1'b0, target: '0};
        if (exception_valid)
        begin
            redirect = '{valid: 1'b1, target: exc_entry};
        end
        else if (bundle[1].valid)
        begin
            if (bundle[1].instr.op == ERET || (bundle[0].valid && bundle[0].instr.op == ERET))
            begin
                redirect = '{valid: 1'b1, target: cp0_epc};
            end
            else if (jr_miss)
            begin
                redirect = '{valid: 1'b1, target: bundle[1].srca};
            end
            else if (br_miss)
            begin
                // not taken resumes after the delay slot
                redirect.valid  = 1'b1;
                redirect.target = bundle[1].taken ? bundle[1].instr.pcbranch : bundle[0].pcplus4;
            end
        end
    end

    assign bpb_update = '{wen:    bundle[1].valid & bundle[1].instr.ctl.branch,
                          pc:     bundle[1].pcplus4 - 32'd4,
                          taken:  bundle[1].taken,
                          target: bundle[1].instr.pcbranch};

    always_comb
    begin
        for (int i = 0; i < 2; i++)
        begin
            bypass.destreg[i] = bundle[i].destreg;
            bypass.result[i]  = results[i].result;
            bypass.wen[i]     = bundle[i].valid & bundle[i].instr.ctl.regwrite;
            bypass.ready[i]   = results[i].ready;
            bypass.hiwrite[i] = bundle[i].valid & bundle[i].instr.ctl.hiwrite;
            bypass.lowrite[i] = bundle[i].valid & bundle[i].instr.ctl.lowrite;
            bypass.hidata[i]  = bundle[i].hiresult;
            bypass.lodata[i]  = bundle[i].loresult;
        end
    end

endmodule

`default_nettype wire

// ==== logic/commit_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module commit_top (
    input  wire                               clk,
    input  wire                               rst_n,
    input  wire commit_pkg::exec_data_t [1:0] bundle,
    input  wire                               exception_valid,
    input  wire isa_pkg::word_t               cp0_epc,
    input  wire                               dmem_en,
    input  wire [1:0]                         dmem_size,
    input  wire isa_pkg::word_t               dmem_addr,
    input  wire isa_pkg::word_t               dmem_rd,
    input  wire                               dmem_data_ok,
    output commit_pkg::redirect_t             redirect,
    output commit_pkg::bypass_upd_t           bypass,
    output commit_pkg::bpb_update_t           bpb_update,
    output logic                              retire,
    output commit_pkg::exec_data_t [1:0]      results
);

    import isa_pkg::*;

    creg_addr_t [4:0] reg_addr;
    word_t [4:0]      reg_data;
    word_t [1:0]      hilo;

    commit_stage u_commit_stage (
        .clk             (clk),
        .rst_n           (rst_n),
        .bundle          (bundle),
        .exception_valid (exception_valid),
        .cp0_epc         (cp0_epc),
        .dmem_en         (dmem_en),
        .dmem_size       (dmem_size),
        .dmem_addr       (dmem_addr),
        .dmem_rd         (dmem_rd),
        .dmem_data_ok    (dmem_data_ok),
        .reg_addr        (reg_addr),
        .reg_data        (reg_data),
        .hilo            (hilo),
        .results         (results),
        .retire          (retire),
        .redirect        (redirect),
        .bypass          (bypass),
        .bpb_update      (bpb_update)
    );

    commit_regfile u_commit_regfile (
        .clk       (clk),
        .rst_n     (rst_n),
        .read_addr (reg_addr),
        .read_data (reg_data),
        .hilo      (hilo),
        .retire    (retire),
        .results   (results)
    );

endmodule

`default_nettype wire

// ==== logic/isa_pkg.sv ====
`default_nettype none

package isa_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  creg_addr_t;

    // operations already decoded upstream
    typedef enum logic [4:0] {
        NOP,
        ADDU,
        SUBU,
        AND,
        OR,
        XOR,
        SLT,
        MFHI,
        MFLO,
        LB,
        LBU,
        LH,
        LHU,
        LW,
        LWL,
        LWR,
        SW,
        BRANCH,
        JR,
        JUMP,
        ERET
    } decoded_op_t;

    typedef struct packed {
        logic regwrite;
        logic memtoreg;
        logic memwrite;
        logic branch;
        logic jump;
        logic jr;
        logic hiwrite;
        logic lowrite;
        // result still to be computed at commit
        logic late;
    } ctl_t;

    typedef struct packed {
        decoded_op_t op;
        ctl_t        ctl;
        word_t       pcbranch;
        word_t       pcjump;
    } instr_t;

endpackage

`default_nettype wire

// ==== logic/late_alu.sv ====
`timescale 1ns/1ns
`default_nettype none

module late_alu (
    input  wire commit_pkg::exec_data_t slot_in,
    input  wire isa_pkg::word_t         opa,
    input  wire isa_pkg::word_t         opb,
    input  wire isa_pkg::word_t         hi,
    input  wire isa_pkg::word_t         lo,
    output commit_pkg::exec_data_t      slot_out
);

    import isa_pkg::*;

    word_t late_result;

    always_comb
    begin
        case (slot_in.instr.op)
            ADDU:    late_result = opa + opb;
            SUBU:    late_result = opa - opb;
            AND:     late_result = opa & opb;
            OR:      late_result = opa | opb;
            XOR:     late_result = opa ^ opb;
            SLT:     late_result = {31'd0, $signed(opa) < $signed(opb)};
            MFHI:    late_result = hi;
            MFLO:    late_result = lo;
            default: late_result = slot_in.result;
        endcase
    end

    // early results pass through untouched
    always_comb
    begin
        slot_out = slot_in;
        if (slot_in.instr.ctl.late)
        begin
            slot_out.result = late_result;
        end
        slot_out.ready = 1'b1;
    end

endmodule

`default_nettype wire

// ==== logic/load_format.sv ====
`timescale 1ns/1ns
`default_nettype none

module load_format (
    input  wire isa_pkg::word_t      raw,
    input  wire [1:0]                addr_lo,
    input  wire isa_pkg::decoded_op_t op,
    input  wire isa_pkg::word_t      old_value,
    output isa_pkg::word_t           formatted
);

    import isa_pkg::*;

    logic [7:0]  mem_byte;
    logic [15:0] mem_half;

    // big-endian lanes, address 0 is the top byte
    always_comb
    begin
        case (addr_lo)
            2'd0:    mem_byte = raw[31:24];
            2'd1:    mem_byte = raw[23:16];
            2'd2:    mem_byte = raw[15:8];
            default: mem_byte = raw[7:0];
        endcase
        mem_half = addr_lo[1] ? raw[15:0] : raw[31:16];
    end

    always_comb
    begin
        case (op)
            LB:  formatted = {{24{mem_byte[7]}}, mem_byte};
            LBU: formatted = {24'd0, mem_byte};
            LH:  formatted = {{16{mem_half[15]}}, mem_half};
            LHU: formatted = {16'd0, mem_half};
            LWL:
            begin
                // upper part from memory, low bytes kept
                case (addr_lo)
                    2'd0:    formatted = raw;
                    2'd1:    formatted = {raw[23:0], old_value[7:0]};
                    2'd2:    formatted = {raw[15:0], old_value[15:0]};
                    default: formatted = {raw[7:0], old_value[23:0]};
                endcase
            end
            LWR:
            begin
                // lower part from memory, high bytes kept
                case (addr_lo)
                    2'd0:    formatted = {old_value[31:8], raw[31:24]};
                    2'd1:    formatted = {old_value[31:16], raw[31:16]};
                    2'd2:    formatted = {old_value[31:24], raw[31:8]};
                    default: formatted = raw;
                endcase
            end
            default: formatted = raw;
        endcase
    end

endmodule

`default_nettype wire

// ==== logic/load_merge.sv ====
`timescale 1ns/1ns
`default_nettype none

module load_merge (
    input  wire commit_pkg::exec_data_t slot_in,
    input  wire commit_pkg::mem_resp_t  resp,
    input  wire isa_pkg::word_t         formatted,
    input  wire                         data_done,
    output commit_pkg::exec_data_t      slot_out
);

    always_comb
    begin
        slot_out = slot_in;
        if (slot_in.instr.ctl.memtoreg)
        begin
            slot_out.result = formatted;
        end
        // stores only wait for the ack
        slot_out.ready = data_done;
    end

endmodule

`default_nettype wire

// ==== tests/commit_model.svh ====
`ifndef COMMIT_MODEL_SVH
`define COMMIT_MODEL_SVH

// architectural state as the testbench expects it
word_t shadow_regs [0:31];
word_t shadow_hi;
word_t shadow_lo;

task automatic clear_shadow();
    for (int r = 0; r < 32; r++)
    begin
        shadow_regs[r] = '0;
    end
    shadow_hi = '0;
    shadow_lo = '0;
endtask

function automatic word_t alu_expect(exec_data_t s);
    word_t a;
    word_t b;
    a = shadow_regs[s.srcreg_a];
    b = shadow_regs[s.srcreg_b];
    if (!s.instr.ctl.late)
        return s.result;
    case (s.instr.op)
        ADDU:    return a + b;
        SUBU:    return a - b;
        AND:     return a & b;
        OR:      return a | b;
        XOR:     return a ^ b;
        SLT:     return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        MFHI:    return shadow_hi;
        MFLO:    return shadow_lo;
        default: return s.result;
    endcase
endfunction

// byte k of a big-endian word sits at bits 31-8k
function automatic word_t format_load(decoded_op_t op, word_t raw, logic [1:0] addr_lo,
                                      word_t old_value);
    int          k;
    logic [7:0]  b;
    logic [15:0] h;
    word_t       low_mask;
    k = addr_lo;
    b = 8'(raw >> (8 * (3 - k)));
    h = 16'(raw >> (16 * (1 - k / 2)));
    case (op)
        LB:      return {{24{b[7]}}, b};
        LBU:     return {24'd0, b};
        LH:      return {{16{h[15]}}, h};
        LHU:     return {16'd0, h};
        LWL:
        begin
            low_mask = (k == 0) ? 32'd0 : 32'hffff_ffff >> (32 - 8 * k);
            return (raw << (8 * k)) | (old_value & low_mask);
        end
        LWR:
        begin
            low_mask = 32'hffff_ffff >> (8 * (3 - k));
            return (old_value & ~low_mask) | (raw >> (8 * (3 - k)));
        end
        default: return raw;
    endcase
endfunction

function automatic exec_data_t expected_slot(exec_data_t s, logic mem_done, word_t raw,
                                             word_t addr);
    exec_data_t e;
    e = s;
    if (s.instr.ctl.memtoreg || s.instr.ctl.memwrite)
    begin
        if (s.instr.ctl.memtoreg)
            e.result = format_load(s.instr.op, raw, addr[1:0], shadow_regs[s.destreg]);
        e.ready = mem_done;
    end
    else
    begin
        e.result = alu_expect(s);
        e.ready  = 1'b1;
    end
    return e;
endfunction

// exception, then ERET, then JR miss, then branch miss
function automatic redirect_t pick_redirect(logic exc, word_t epc, exec_data_t [1:0] b);
    redirect_t r;
    r.valid  = 1'b1;
    r.target = '0;
    if (exc)
        r.target = exc_entry;
    else if (!b[1].valid)
        r.valid = 1'b0;
    else if (b[1].instr.op == ERET || (b[0].valid && b[0].instr.op == ERET))
        r.target = epc;
    else if (b[1].instr.ctl.jr && (!b[1].pred.taken || b[1].pred.destpc != b[1].srca))
        r.target = b[1].srca;
    else if (b[1].instr.ctl.branch && b[1].taken != b[1].pred.taken)
        r.target = b[1].taken ? b[1].instr.pcbranch : b[0].pcplus4;
    else
        r.valid = 1'b0;
    return r;
endfunction

function automatic bpb_update_t predictor_record(exec_data_t s);
    bpb_update_t u;
    u.wen    = s.valid & s.instr.ctl.branch;
    u.pc     = s.pcplus4 - 32'd4;
    u.taken  = s.taken;
    u.target = s.instr.pcbranch;
    return u;
endfunction

function automatic bypass_upd_t bypass_expect(exec_data_t [1:0] e);
    bypass_upd_t u;
    for (int i = 0; i < 2; i++)
    begin
        u.destreg[i] = e[i].destreg;
        u.result[i]  = e[i].result;
        u.wen[i]     = e[i].valid & e[i].instr.ctl.regwrite;
        u.ready[i]   = e[i].ready;
        u.hiwrite[i] = e[i].valid & e[i].instr.ctl.hiwrite;
        u.lowrite[i] = e[i].valid & e[i].instr.ctl.lowrite;
        u.hidata[i]  = e[i].hiresult;
        u.lodata[i]  = e[i].loresult;
    end
    return u;
endfunction

// older slot first, the younger one overwrites
task automatic apply_retire(input exec_data_t [1:0] e);
    for (int s = 1; s >= 0; s--)
    begin
        if (e[s].valid && e[s].instr.ctl.regwrite && e[s].destreg != 5'd0)
            shadow_regs[e[s].destreg] = e[s].result;
        if (e[s].valid && e[s].instr.ctl.hiwrite)
            shadow_hi = e[s].hiresult;
        if (e[s].valid && e[s].instr.ctl.lowrite)
            shadow_lo = e[s].loresult;
    end
endtask

`endif

// ==== tests/commit_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

module commit_tb;

    import isa_pkg::*;
    import commit_pkg::*;

    localparam int clk_period   = 40;
    localparam int reset_cycles = 10;
    localparam int num_bundles  = 300;
    localparam int watchdog_ns  = num_bundles * 8 * clk_period + reset_cycles * clk_period;

    logic             clk;
    logic             rst_n;
    exec_data_t [1:0] bundle;
    logic             exception_valid;
    word_t            cp0_epc;
    logic             dmem_en;
    logic [1:0]       dmem_size;
    word_t            dmem_addr;
    word_t            dmem_rd;
    logic             dmem_data_ok;
    redirect_t        redirect;
    bypass_upd_t      bypass;
    bpb_update_t      bpb_update;
    logic             retire;
    exec_data_t [1:0] results;

    int errors;
    int checks;

    `include "commit_model.svh"

    commit_top dut (
        .clk             (clk),
        .rst_n           (rst_n),
        .bundle          (bundle),
        .exception_valid (exception_valid),
        .cp0_epc         (cp0_epc),
        .dmem_en         (dmem_en),
        .dmem_size       (dmem_size),
        .dmem_addr       (dmem_addr),
        .dmem_rd         (dmem_rd),
        .dmem_data_ok    (dmem_data_ok),
        .redirect        (redirect),
        .bypass          (bypass),
        .bpb_update      (bpb_update),
        .retire          (retire),
        .results         (results)
    );

    initial
    begin
        clk = 1'b0;
        forever
        begin
            #(clk_period / 2);
            clk = ~clk;
        end
    end

    initial
    begin
        #(watchdog_ns);
        $display("watchdog expired, the run did not finish in time");
        $display("Simulation failed");
        $finish;
    end

    task automatic log_mismatch(input string msg);
        errors++;
        $display("error at %0t ns: %s", $time, msg);
    endtask

    function automatic exec_data_t random_alu_slot();
        exec_data_t  s;
        decoded_op_t alu_ops [0:7] = '{ADDU, SUBU, AND, OR, XOR, SLT, MFHI, MFLO};
        s = '0;
        s.instr.op           = alu_ops[$urandom_range(7)];
        s.instr.ctl.regwrite = 1'b1;
        s.instr.ctl.late     = ($urandom_range(3) != 0);
        s.instr.ctl.hiwrite  = ($urandom_range(7) == 0);
        s.instr.ctl.lowrite  = ($urandom_range(7) == 0);
        s.pcplus4            = $urandom & 32'hffff_fffc;
        s.srcreg_a           = 5'($urandom_range(31));
        s.srcreg_b           = 5'($urandom_range(31));
        s.srca               = $urandom;
        s.result             = $urandom;
        s.destreg            = 5'($urandom_range(31));
        s.hiresult           = $urandom;
        s.loresult           = $urandom;
        s.valid              = ($urandom_range(7) != 0);
        return s;
    endfunction

    function automatic exec_data_t random_mem_slot(output word_t addr, output logic [1:0] size);
        exec_data_t  s;
        decoded_op_t mem_ops [0:7] = '{LB, LBU, LH, LHU, LW, LWL, LWR, SW};
        s = random_alu_slot();
        s.instr.op  = mem_ops[$urandom_range(7)];
        s.instr.ctl = '0;
        s.valid     = 1'b1;
        addr        = $urandom;
        case (s.instr.op)
            LB, LBU:  size = 2'd0;
            LH, LHU:
            begin
                size    = 2'd1;
                addr[0] = 1'b0;
            end
            LWL, LWR: size = 2'd2;
            default:
            begin
                size      = 2'd2;
                addr[1:0] = 2'b00;
            end
        endcase
        if (s.instr.op == SW)
            s.instr.ctl.memwrite = 1'b1;
        else
            s.instr.ctl = '{regwrite: 1'b1, memtoreg: 1'b1, default: 1'b0};
        return s;
    endfunction

    function automatic exec_data_t random_ctrl_slot();
        exec_data_t s;
        s = random_alu_slot();
        s.instr.ctl      = '0;
        s.instr.pcbranch = $urandom & 32'hffff_fffc;
        s.taken          = 1'($urandom_range(1));
        s.pred.taken     = 1'($urandom_range(1));
        s.pred.destpc    = $urandom & 32'hffff_fffc;
        case ($urandom_range(3))
            0:
            begin
                s.instr.op         = BRANCH;
                s.instr.ctl.branch = 1'b1;
            end
            1:
            begin
                s.instr.op     = JR;
                s.instr.ctl.jr = 1'b1;
                // half the time the prediction was right
                if ($urandom_range(1) == 0)
                    s.pred.destpc = s.srca;
            end
            2:       s.instr.op = ERET;
            default:
            begin
                s.instr.op       = JUMP;
                s.instr.ctl.jump = 1'b1;
            end
        endcase
        return s;
    endfunction

    task automatic check_outputs(input exec_data_t [1:0] b, input exec_data_t [1:0] exp,
                                 input logic exc, input word_t epc, input logic exp_retire);
        exec_data_t  got_slot;
        exec_data_t  want_slot;
        bypass_upd_t got_bypass;
        bypass_upd_t want_bypass;
        redirect_t   want_redirect;
        bpb_update_t want_bpb;
        checks++;
        assert (retire === exp_retire)
        else log_mismatch($sformatf("retire %b, expected %b", retire, exp_retire));
        want_bypass = bypass_expect(exp);
        got_bypass  = bypass;
        for (int i = 0; i < 2; i++)
        begin
            assert (results[i].ready === exp[i].ready)
            else log_mismatch($sformatf("slot %0d ready %b, expected %b", i,
                                        results[i].ready, exp[i].ready));
            // load data is only defined once the response is in
            if (exp[i].ready)
            begin
                assert (results[i].result === exp[i].result)
                else log_mismatch($sformatf("slot %0d result %h, expected %h", i,
                                            results[i].result, exp[i].result));
            end
            else
            begin
                got_bypass.result[i]  = '0;
                want_bypass.result[i] = '0;
            end
            got_slot  = results[i];
            want_slot = exp[i];
            got_slot.result  = '0;
            want_slot.result = '0;
            assert (got_slot === want_slot)
            else log_mismatch($sformatf("slot %0d record fields changed", i));
        end
        assert (got_bypass === want_bypass)
        else log_mismatch($sformatf("bypass %h, expected %h", got_bypass, want_bypass));
        want_redirect = pick_redirect(exc, epc, b);
        assert (redirect.valid === want_redirect.valid &&
                (!want_redirect.valid || redirect.target === want_redirect.target))
        else log_mismatch($sformatf("redirect %b/%h, expected %b/%h", redirect.valid,
                                    redirect.target, want_redirect.valid, want_redirect.target));
        want_bpb = predictor_record(b[1]);
        assert (bpb_update === want_bpb)
        else log_mismatch($sformatf("predictor update %h, expected %h", bpb_update, want_bpb));
    endtask

    task automatic run_bundle(input bit first);
        exec_data_t [1:0] b;
        exec_data_t [1:0] exp;
        word_t            addr;
        logic [1:0]       size;
        logic             has_mem;
        logic             exc;
        word_t            epc;
        int               kind;
        int               latency;
        int               cycle;
        logic             exp_retire;
        logic             finished;
        b[1]    = random_alu_slot();
        b[0]    = random_alu_slot();
        addr    = $urandom;
        size    = 2'd2;
        has_mem = 1'b0;
        kind    = first ? 3 : $urandom_range(3);
        case (kind)
            0:
            begin
                b[$urandom_range(1)] = random_mem_slot(addr, size);
                has_mem = 1'b1;
            end
            1:
            begin
                b[1] = random_ctrl_slot();
                if ($urandom_range(7) == 0)
                begin
                    b[0].instr.op  = ERET;
                    b[0].instr.ctl = '0;
                    b[0].valid     = 1'b1;
                end
            end
            2:       b[0].destreg = b[1].destreg;
            default: ;
        endcase
        if (first)
        begin
            // right after reset both moves must read zero
            b[1].instr.op = MFHI;
            b[0].instr.op = MFLO;
            b[1].instr.ctl.late = 1'b1;
            b[0].instr.ctl.late = 1'b1;
        end
        exc      = ($urandom_range(7) == 0);
        epc      = $urandom & 32'hffff_fffc;
        latency  = $urandom_range(5);
        cycle    = 0;
        finished = 1'b0;
        while (!finished)
        begin
            @(negedge clk);
            if (cycle == 0)
            begin
                bundle          = b;
                exception_valid = exc;
                cp0_epc         = epc;
                dmem_en         = has_mem;
                dmem_addr       = addr;
                dmem_size       = size;
            end
            dmem_data_ok = has_mem && (cycle == latency);
            if (dmem_data_ok)
                dmem_rd = $urandom;
            #1;
            exp_retire = !has_mem || dmem_data_ok;
            for (int i = 0; i < 2; i++)
            begin
                exp[i] = expected_slot(b[i], dmem_data_ok, dmem_rd, addr);
            end
            check_outputs(b, exp, exc, epc, exp_retire);
            finished = retire;
            @(posedge clk);
            if (finished)
            begin
                apply_retire(exp);
            end
            cycle++;
        end
    endtask

    initial
    begin
        void'($urandom(32'h992f_ca31));
        errors          = 0;
        checks          = 0;
        rst_n           = 1'b0;
        bundle          = '0;
        exception_valid = 1'b0;
        cp0_epc         = '0;
        dmem_en         = 1'b0;
        dmem_size       = '0;
        dmem_addr       = '0;
        dmem_rd         = '0;
        dmem_data_ok    = 1'b0;
        clear_shadow();
        repeat (reset_cycles) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        for (int n = 0; n < num_bundles; n++)
        begin
            run_bundle(n == 0);
        end
        $display("bundles %0d, cycles checked %0d, errors %0d", num_bundles, checks, errors);
        if (errors == 0)
            $display("Simulation completed successfully");
        else
            $display("Simulation failed");
        $finish;
    end

endmodule

`default_nettype wire
